// File: delay_queue_pkg.sv
`default_nettype none

package delay_queue_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int TAG_W = 8;
    localparam int CNT_W = 6;
    localparam int ENTRY_W = TAG_W + CNT_W;
    localparam int DEPTH = 8;
    localparam int IDX_W = 3;

    // Idle cycles between two releases
    localparam int REL_GAP_LEN = 2;
    localparam int GAP_W = 2;
    localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(REL_GAP_LEN - 1);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [CNT_W-1:0] cnt; // Count sits in the low bits of each slot
    } entry_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } release_t;

    typedef enum logic [1:0] {
        AGE_RUN      = 2'd0,
        AGE_HOLD     = 2'd1,
        AGE_EXPEDITE = 2'd2
    } age_cmd_e;

    typedef enum logic [1:0] {
        REL_SCAN = 2'd0,
        REL_GAP  = 2'd1
    } rel_state_e;

endpackage

`default_nettype wire

// File: onehot_mux.sv
`timescale 1ns/1ps
`default_nettype none

module onehot_mux (
    input  wire logic [delay_queue_pkg::DEPTH*delay_queue_pkg::ENTRY_W-1:0] data_in,
    input  wire logic [delay_queue_pkg::DEPTH-1:0]                          sel,
    output delay_queue_pkg::entry_t                                         data_out
);

    // Zero when no select bit is set
    always_comb begin
        data_out = '0;
        for (int i = 0; i < delay_queue_pkg::DEPTH; i++) begin
            if (sel[i]) begin
                data_out = data_in[i*delay_queue_pkg::ENTRY_W +: delay_queue_pkg::ENTRY_W];
            end
        end
    end

endmodule

`default_nettype wire

// File: tag_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tag_queue (
    input  wire logic                                                     clk,
    input  wire logic                                                     rst,
    input  wire logic                                                     wr,
    input  delay_queue_pkg::entry_t                                       wr_entry,
    input  wire logic                                                     rd,
    input  wire logic [delay_queue_pkg::DEPTH*delay_queue_pkg::CNT_W-1:0] new_cnt_vector,
    input  wire logic [delay_queue_pkg::DEPTH-1:0]                        modify_mask,
    output logic      [delay_queue_pkg::DEPTH*delay_queue_pkg::CNT_W-1:0] cnt_vector,
    output delay_queue_pkg::entry_t                                       head,
    output logic                                                          full,
    output logic                                                          empty
);

    logic [delay_queue_pkg::DEPTH-1:0] wr_ptr;
    logic [delay_queue_pkg::DEPTH-1:0] rd_ptr;
    logic                              wr_wrap;
    logic                              rd_wrap;
    logic [delay_queue_pkg::IDX_W-1:0] wr_idx;
    logic                              do_wr;
    logic                              do_rd;

    delay_queue_pkg::entry_t mem [delay_queue_pkg::DEPTH];

    logic [delay_queue_pkg::DEPTH*delay_queue_pkg::ENTRY_W-1:0] flat_queue;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Status and pointer control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Same slot on both pointers: empty on equal wrap, full on differing wrap
    assign empty = (wr_ptr == rd_ptr) && (wr_wrap == rd_wrap);
    assign full  = (wr_ptr == rd_ptr) && (wr_wrap != rd_wrap);

    assign do_wr = wr && !full; // Writes into a full queue are dropped
    assign do_rd = rd && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= delay_queue_pkg::DEPTH'(1);
            rd_ptr  <= delay_queue_pkg::DEPTH'(1);
            wr_wrap <= 1'b0;
            rd_wrap <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= {wr_ptr[delay_queue_pkg::DEPTH-2:0], wr_ptr[delay_queue_pkg::DEPTH-1]};
                if (wr_ptr[delay_queue_pkg::DEPTH-1]) begin
                    wr_wrap <= ~wr_wrap;
                end
            end
            if (do_rd) begin
                rd_ptr <= {rd_ptr[delay_queue_pkg::DEPTH-2:0], rd_ptr[delay_queue_pkg::DEPTH-1]};
                if (rd_ptr[delay_queue_pkg::DEPTH-1]) begin
                    rd_wrap <= ~rd_wrap;
                end
            end
        end
    end

    // One-hot write pointer to slot index
    always_comb begin
        wr_idx = '0;
        for (int i = 0; i < delay_queue_pkg::DEPTH; i++) begin
            if (wr_ptr[i]) begin
                wr_idx = wr_idx | i[delay_queue_pkg::IDX_W-1:0];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        for (int i = 0; i < delay_queue_pkg::DEPTH; i++) begin
            if (modify_mask[i]) begin
                mem[i].cnt <= new_cnt_vector[i*delay_queue_pkg::CNT_W +: delay_queue_pkg::CNT_W];
            end
        end
        if (do_wr) begin
            mem[wr_idx] <= wr_entry; // Comes last so it overrides a count update
        end
    end

    // Flattened views of the whole array
    always_comb begin
        for (int i = 0; i < delay_queue_pkg::DEPTH; i++) begin
            flat_queue[i*delay_queue_pkg::ENTRY_W +: delay_queue_pkg::ENTRY_W] = mem[i];
            cnt_vector[i*delay_queue_pkg::CNT_W +: delay_queue_pkg::CNT_W]     = mem[i].cnt;
        end
    end

    onehot_mux head_mux_i (
        .data_in  (flat_queue),
        .sel      (rd_ptr),
        .data_out (head)
    );

endmodule

`default_nettype wire

// File: count_ager.sv
`timescale 1ns/1ps
`default_nettype none

module count_ager (
    input  delay_queue_pkg::age_cmd_e                                     age_cmd,
    input  wire logic [delay_queue_pkg::DEPTH*delay_queue_pkg::CNT_W-1:0] cnt_vector,
    output logic      [delay_queue_pkg::DEPTH*delay_queue_pkg::CNT_W-1:0] new_cnt_vector,
    output logic      [delay_queue_pkg::DEPTH-1:0]                        modify_mask
);

    logic [delay_queue_pkg::CNT_W-1:0] cur_cnt;
    logic [delay_queue_pkg::CNT_W-1:0] nxt_cnt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Per-slot aging
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        new_cnt_vector = '0;
        modify_mask    = '0;
        cur_cnt        = '0;
        nxt_cnt        = '0;
        for (int i = 0; i < delay_queue_pkg::DEPTH; i++) begin
            cur_cnt = cnt_vector[i*delay_queue_pkg::CNT_W +: delay_queue_pkg::CNT_W];
            unique case (age_cmd)
                delay_queue_pkg::AGE_RUN: begin
                    // Counts stop at zero
                    if (cur_cnt != '0) begin
                        nxt_cnt = cur_cnt - 1'b1;
                    end else begin
                        nxt_cnt = cur_cnt;
                    end
                end
                delay_queue_pkg::AGE_EXPEDITE: begin
                    nxt_cnt = '0;
                end
                default: begin
                    nxt_cnt = cur_cnt; // Hold, and the unused encoding
                end
            endcase

            new_cnt_vector[i*delay_queue_pkg::CNT_W +: delay_queue_pkg::CNT_W] = nxt_cnt;

            // Only flag slots whose count really moves
            modify_mask[i] = (nxt_cnt != cur_cnt);
        end
    end

endmodule

`default_nettype wire

// File: release_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module release_ctrl (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  delay_queue_pkg::entry_t   head,
    input  wire logic                 empty,
    output logic                      rd,
    output delay_queue_pkg::release_t rel
);

    delay_queue_pkg::rel_state_e state;

    logic [delay_queue_pkg::GAP_W-1:0] gap_cnt;
    logic                              expired;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Release decision
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign expired = !empty && (head.cnt == '0);

    // The pop happens in the decision cycle itself
    assign rd = (state == delay_queue_pkg::REL_SCAN) && expired;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State, gap counter and output
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= delay_queue_pkg::REL_SCAN;
            gap_cnt <= '0;
            rel     <= '0;
        end else begin
            rel.valid <= rd; // One-cycle pulse after the decision
            rel.tag   <= head.tag;

            case (state)
                delay_queue_pkg::REL_SCAN: begin
                    if (rd) begin
                        state   <= delay_queue_pkg::REL_GAP;
                        gap_cnt <= delay_queue_pkg::GAP_LAST;
                    end
                end
                delay_queue_pkg::REL_GAP: begin
                    // Sits here for the full gap, the output pulse included
                    if (gap_cnt == '0) begin
                        state <= delay_queue_pkg::REL_SCAN;
                    end else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= delay_queue_pkg::REL_SCAN;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: delay_queue_top.sv
`timescale 1ns/1ps
`default_nettype none

module delay_queue_top (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 wr,
    input  delay_queue_pkg::entry_t   wr_entry,
    input  delay_queue_pkg::age_cmd_e age_cmd,
    output delay_queue_pkg::release_t rel,
    output logic                      full,
    output logic                      empty
);

    logic [delay_queue_pkg::DEPTH*delay_queue_pkg::CNT_W-1:0] cnt_vector;
    logic [delay_queue_pkg::DEPTH*delay_queue_pkg::CNT_W-1:0] new_cnt_vector;
    logic [delay_queue_pkg::DEPTH-1:0]                        modify_mask;
    logic                                                     rd;

    delay_queue_pkg::entry_t head;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Queue with count update path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    tag_queue tag_queue_i (
        .clk            (clk),
        .rst            (rst),
        .wr             (wr),
        .wr_entry       (wr_entry),
        .rd             (rd),
        .new_cnt_vector (new_cnt_vector),
        .modify_mask    (modify_mask),
        .cnt_vector     (cnt_vector),
        .head           (head),
        .full           (full),
        .empty          (empty)
    );

    count_ager count_ager_i (
        .age_cmd        (age_cmd),
        .cnt_vector     (cnt_vector),
        .new_cnt_vector (new_cnt_vector),
        .modify_mask    (modify_mask)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Head release
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    release_ctrl release_ctrl_i (
        .clk   (clk),
        .rst   (rst),
        .head  (head),
        .empty (empty),
        .rd    (rd),
        .rel   (rel)
    );

endmodule

`default_nettype wire

// File: delay_queue_chk.sv
`timescale 1ns/1ps
`default_nettype none

module delay_queue_chk (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 rd,
    input  delay_queue_pkg::release_t rel,
    input  wire logic                 full,
    input  wire logic                 empty
);

    localparam logic [2:0] MIN_SPACING = 3'(delay_queue_pkg::REL_GAP_LEN + 1);

    logic [2:0] since_rel; // Cycles since the last release pulse, saturating

    always_ff @(posedge clk) begin
        if (rst) begin
            since_rel <= '1;
        end else if (rel.valid) begin
            since_rel <= 3'd1;
        end else if (since_rel != '1) begin
            since_rel <= since_rel + 3'd1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_no_rd_when_empty: assert property (@(posedge clk) disable iff (rst) rd |-> !empty)
        else $error("Pop raised while the queue is empty");

    a_rel_single_pulse: assert property (@(posedge clk) disable iff (rst)
        rel.valid |=> !rel.valid)
        else $error("Release pulse lasted more than one cycle");

    a_not_full_and_empty: assert property (@(posedge clk) disable iff (rst) !(full && empty))
        else $error("Queue reports full and empty at once");

    // Releases must keep the gap between them
    a_rel_spacing: assert property (@(posedge clk) disable iff (rst)
        rel.valid |-> (since_rel >= MIN_SPACING))
        else $error("Release came inside the gap after the previous one");

endmodule

bind delay_queue_top delay_queue_chk delay_queue_chk_i (
    .clk   (clk),
    .rst   (rst),
    .rd    (rd),
    .rel   (rel),
    .full  (full),
    .empty (empty)
);

`default_nettype wire

// File: delay_queue_tb.sv
`timescale 1ns/1ps
`default_nettype none

module delay_queue_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_CYCLES   = 3000;
    localparam int TIMEOUT_NS   = (MAX_CYCLES + 50) * CLK_PERIOD;

    logic                      clk;
    logic                      rst;
    logic                      wr;
    delay_queue_pkg::entry_t   wr_entry;
    delay_queue_pkg::age_cmd_e age_cmd;
    delay_queue_pkg::release_t rel;
    logic                      full;
    logic                      empty;

    // Reference model state
    delay_queue_pkg::entry_t           model_q[$];
    delay_queue_pkg::rel_state_e       m_state;
    int                                m_gap_left;
    logic                              exp_valid;
    logic [delay_queue_pkg::TAG_W-1:0] exp_tag;

    integer seed;
    int     err_cnt;
    int     cycle_num;
    int     last_rel_cycle;
    int     rel_cnt;
    int     drop_cnt;
    int     start_cnt;
    int     rel_before;

    delay_queue_top delay_queue_top_i (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr),
        .wr_entry (wr_entry),
        .age_cmd  (age_cmd),
        .rel      (rel),
        .full     (full),
        .empty    (empty)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h at cycle %0d",
                     name, actual, expected, cycle_num);
            $display("Checks failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One clock edge, using the inputs held during the cycle before it
    task automatic model_step();
        delay_queue_pkg::entry_t e;
        logic                    pop;
        logic                    was_full;
        pop      = 1'b0;
        was_full = (model_q.size() == delay_queue_pkg::DEPTH);
        if (model_q.size() > 0) begin
            e   = model_q[0];
            pop = (m_state == delay_queue_pkg::REL_SCAN) && (e.cnt == '0);
        end
        exp_valid = pop;
        if (pop) begin
            exp_tag = e.tag;
            void'(model_q.pop_front());
            m_state    = delay_queue_pkg::REL_GAP;
            m_gap_left = delay_queue_pkg::REL_GAP_LEN;
        end else if (m_state == delay_queue_pkg::REL_GAP) begin
            m_gap_left--;
            if (m_gap_left == 0) begin
                m_state = delay_queue_pkg::REL_SCAN;
            end
        end
        foreach (model_q[i]) begin
            e = model_q[i];
            if (age_cmd == delay_queue_pkg::AGE_EXPEDITE) begin
                e.cnt = '0;
            end else if (age_cmd == delay_queue_pkg::AGE_RUN && e.cnt != '0) begin
                e.cnt = e.cnt - 1'b1;
            end
            model_q[i] = e;
        end
        // The new entry keeps its written count even while aging runs
        if (wr && was_full) begin
            drop_cnt++;
        end else if (wr) begin
            model_q.push_back(wr_entry);
        end
    endtask

    // Advance one edge and compare the DUT with the model
    task automatic next_cycle();
        @(posedge clk);
        #1;
        model_step();
        cycle_num++;
        if (rel.valid) begin
            check("rel.valid spacing ok",
                  32'((cycle_num - last_rel_cycle) > delay_queue_pkg::REL_GAP_LEN), 32'd1);
            last_rel_cycle = cycle_num;
            rel_cnt++;
        end
        check("rel.valid", 32'(rel.valid), 32'(exp_valid));
        if (exp_valid) begin
            check("rel.tag", 32'(rel.tag), 32'(exp_tag));
        end
        check("full", 32'(full), 32'(model_q.size() == delay_queue_pkg::DEPTH));
        check("empty", 32'(empty), 32'(model_q.size() == 0));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic drive_random(input int unsigned wr_pct, input int unsigned run_pct,
                                input int unsigned hold_pct, input int unsigned cnt_min,
                                input int unsigned cnt_max);
        logic [31:0] pick;
        logic [31:0] val;
        pick = $unsigned($random(seed)) % 100;
        wr   = (pick < wr_pct);
        val  = $unsigned($random(seed));
        wr_entry.tag = val[delay_queue_pkg::TAG_W-1:0];
        val  = cnt_min + $unsigned($random(seed)) % (cnt_max - cnt_min + 1);
        wr_entry.cnt = val[delay_queue_pkg::CNT_W-1:0];
        pick = $unsigned($random(seed)) % 100;
        if (pick < run_pct) begin
            age_cmd = delay_queue_pkg::AGE_RUN;
        end else if (pick < run_pct + hold_pct) begin
            age_cmd = delay_queue_pkg::AGE_HOLD;
        end else begin
            age_cmd = delay_queue_pkg::AGE_EXPEDITE;
        end
    endtask

    task automatic run_random(input int n, input int unsigned wr_pct,
                              input int unsigned run_pct, input int unsigned hold_pct,
                              input int unsigned cnt_min, input int unsigned cnt_max);
        repeat (n) begin
            drive_random(wr_pct, run_pct, hold_pct, cnt_min, cnt_max);
            next_cycle();
        end
    endtask

    task automatic drive_idle(input delay_queue_pkg::age_cmd_e cmd);
        wr      = 1'b0;
        age_cmd = cmd;
    endtask

    initial begin
        seed           = 32'h1e39_a5e0;
        err_cnt        = 0;
        cycle_num      = 0;
        last_rel_cycle = -1000;
        rel_cnt        = 0;
        drop_cnt       = 0;
        m_state        = delay_queue_pkg::REL_SCAN;
        m_gap_left     = 0;
        exp_valid      = 1'b0;
        exp_tag        = '0;
        rst            = 1'b1;
        wr             = 1'b0;
        wr_entry       = '0;
        age_cmd        = delay_queue_pkg::AGE_HOLD;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        run_random(1400, 40, 70, 20, 0, 20); // Mixed traffic
        run_random(300, 30, 0, 100, 0, 20);  // Hold, only zero counts may leave
        run_random(150, 90, 0, 100, 1, 20);  // Fill up and overflow

        // Expedite drains everything, one release per gap
        start_cnt  = model_q.size();
        rel_before = rel_cnt;
        drive_idle(delay_queue_pkg::AGE_EXPEDITE);
        repeat (3 * delay_queue_pkg::DEPTH + 4) next_cycle();
        check("empty after expedite", 32'(empty), 32'd1);
        check("releases during expedite", 32'(rel_cnt - rel_before), 32'(start_cnt));

        // Count 0 into an idle, empty queue
        drive_idle(delay_queue_pkg::AGE_HOLD);
        while (m_state != delay_queue_pkg::REL_SCAN) next_cycle();
        wr           = 1'b1;
        wr_entry.tag = 8'h5a;
        wr_entry.cnt = '0;
        next_cycle();
        drive_idle(delay_queue_pkg::AGE_HOLD);
        check("rel.valid one cycle after write", 32'(rel.valid), 32'd0);
        next_cycle();
        check("rel.valid two cycles after write", 32'(rel.valid), 32'd1);
        check("rel.tag two cycles after write", 32'(rel.tag), 32'h5a);

        run_random(400, 50, 60, 25, 0, 12);

        check("dropped writes seen", 32'(drop_cnt > 0), 32'd1);
        check("releases seen", 32'(rel_cnt > 0), 32'd1);

        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("Checks failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

// File: project.f
delay_queue_pkg.sv
onehot_mux.sv
tag_queue.sv
count_ager.sv
release_ctrl.sv
delay_queue_top.sv
delay_queue_chk.sv
delay_queue_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the delay queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module delay_queue_tb -f project.f -o sim_delay_queue

status=0
./obj_dir/sim_delay_queue > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
echo "Simulation finished without errors"
